//--- hdl/mcl_bridge_macros.svh
`ifndef MCL_BRIDGE_MACROS_SVH
`define MCL_BRIDGE_MACROS_SVH

// ----------------------------------------------------------------------
// bridge geometry
// ----------------------------------------------------------------------
`define MCL_WORD_W 32 // host register word

`define MCL_FLIT_W 128 // fabric flit

`define MCL_WORDS_PER_FLIT 4

`define MCL_RX_DEPTH 8 // receive fifo entries
`define MCL_CREDIT_W 4 // holds 0..MCL_RX_DEPTH

`endif

//--- hdl/mcl_bridge_pkg.sv
`include "mcl_bridge_macros.svh"

package mcl_bridge_pkg;

  // ----------------------------------------------------------------------
  // data types
  // ----------------------------------------------------------------------
  typedef logic [`MCL_WORD_W-1:0] word_t;
  typedef logic [`MCL_FLIT_W-1:0] flit_t;

  // host register map
  typedef enum logic [1:0] {
    REG_TX_DATA = 2'd0, // write only
    REG_RX_DATA = 2'd1, // read pops one word
    REG_STATUS  = 2'd2, // {rx_empty, tx_busy}
    REG_CREDITS = 2'd3  // free rx fifo slots
  } reg_addr_e;

  typedef enum logic {
    PACK_FILL, // collecting host words
    PACK_SEND  // flit offered to fabric
  } pack_state_e;

endpackage

//--- hdl/mcl_host_regs.sv
`include "mcl_bridge_macros.svh"

module mcl_host_regs (
  input  logic                         clk_i
  ,input  logic                        rst_n_i
  ,input  logic                        wr_stb_i
  ,input  logic                        rd_stb_i
  ,input  mcl_bridge_pkg::reg_addr_e   addr_i
  ,input  mcl_bridge_pkg::word_t       wdata_i
  ,input  logic                        tx_busy_i
  ,input  mcl_bridge_pkg::word_t       rx_word_i
  ,input  logic                        rx_valid_i
  ,input  logic [`MCL_CREDIT_W-1:0]    credits_i
  ,output logic                        tx_push_o
  ,output mcl_bridge_pkg::word_t       tx_word_o
  ,output logic                        rx_pop_o
  ,output mcl_bridge_pkg::word_t       rdata_o
  ,output logic                        rvalid_o
);

  import mcl_bridge_pkg::*;

  word_t rdata_d;

  // ----------------------------------------------------------------------
  // strobe decode
  // ----------------------------------------------------------------------
  assign tx_push_o = wr_stb_i && (addr_i == REG_TX_DATA); // packer drops it when busy
  assign tx_word_o = wdata_i;
  assign rx_pop_o  = rd_stb_i && (addr_i == REG_RX_DATA) && rx_valid_i; // no pop when empty

  // ----------------------------------------------------------------------
  // read mux, one cycle latency
  // ----------------------------------------------------------------------
  always_comb begin
    rdata_d = '0;
    case (addr_i)
      REG_TX_DATA: rdata_d = '0; // write only
      REG_RX_DATA: rdata_d = rx_valid_i ? rx_word_i : '0;
      REG_STATUS:  rdata_d = {{(`MCL_WORD_W-2){1'b0}}, ~rx_valid_i, tx_busy_i};
      REG_CREDITS: rdata_d = {{(`MCL_WORD_W-`MCL_CREDIT_W){1'b0}}, credits_i};
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rd_stb_i) begin
      rdata_o <= rdata_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= rd_stb_i; // every read answers
    end
  end

endmodule

//--- hdl/mcl_tx_packer.sv
`include "mcl_bridge_macros.svh"

module mcl_tx_packer (
  input  logic                    clk_i
  ,input  logic                   rst_n_i
  ,input  logic                   push_i
  ,input  mcl_bridge_pkg::word_t  word_i
  ,input  logic                   mcl_r_i
  ,output logic                   busy_o
  ,output logic                   mcl_v_o
  ,output mcl_bridge_pkg::flit_t  mcl_data_o
);

  import mcl_bridge_pkg::*;

  localparam logic [1:0] LAST_IDX = 2'(`MCL_WORDS_PER_FLIT - 1);

  pack_state_e state_q;
  logic [1:0]  idx_q; // words collected so far
  flit_t       flit_q;
  logic        take;

  assign take = push_i && (state_q == PACK_FILL);

  // ----------------------------------------------------------------------
  // packer fsm
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= PACK_FILL;
      idx_q   <= 2'd0;
    end else begin
      case (state_q)
        PACK_FILL: begin
          if (take) begin
            idx_q <= idx_q + 2'd1; // wraps to 0 after the last word
            if (idx_q == LAST_IDX) begin
              state_q <= PACK_SEND;
            end
          end
        end
        PACK_SEND: begin
          if (mcl_r_i) state_q <= PACK_FILL; // accepted by fabric
        end
        default: state_q <= PACK_FILL;
      endcase
    end
  end

  // newest word enters at the top, word 0 ends up in the low bits
  always_ff @(posedge clk_i) begin
    if (take) begin
      flit_q <= {word_i, flit_q[`MCL_FLIT_W-1:`MCL_WORD_W]};
    end
  end

  assign mcl_v_o    = (state_q == PACK_SEND);
  assign busy_o     = (state_q == PACK_SEND); // host polls this
  assign mcl_data_o = flit_q; // frozen while in send

endmodule

//--- hdl/mcl_rx_fifo.sv
`include "mcl_bridge_macros.svh"

module mcl_rx_fifo (
  input  logic                       clk_i
  ,input  logic                      rst_n_i
  ,input  logic                      mcl_v_i
  ,input  mcl_bridge_pkg::flit_t     mcl_data_i
  ,input  logic                      deq_i
  ,output logic                      mcl_r_o
  ,output mcl_bridge_pkg::flit_t     head_o
  ,output logic                      valid_o
  ,output logic [`MCL_CREDIT_W-1:0]  credits_o
);

  import mcl_bridge_pkg::*;

  localparam int PTR_W = $clog2(`MCL_RX_DEPTH);

  flit_t                    mem [`MCL_RX_DEPTH];
  logic [PTR_W-1:0]         wr_ptr_q;
  logic [PTR_W-1:0]         rd_ptr_q;
  logic [`MCL_CREDIT_W-1:0] credits_q; // free slots
  logic                     enq;
  logic                     deq;

  assign enq = mcl_v_i && mcl_r_o;
  assign deq = deq_i && valid_o;

  // ----------------------------------------------------------------------
  // storage
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem[wr_ptr_q] <= mcl_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (enq) wr_ptr_q <= wr_ptr_q + 1'b1; // depth is a power of two
      if (deq) rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // credit counter
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credits_q <= `MCL_CREDIT_W'(`MCL_RX_DEPTH);
    end else begin
      case ({enq, deq})
        2'b10:   credits_q <= credits_q - 1'b1;
        2'b01:   credits_q <= credits_q + 1'b1;
        default: credits_q <= credits_q; // both or neither
      endcase
    end
  end

  assign credits_o = credits_q;
  assign mcl_r_o   = (credits_q != '0); // full holds off the fabric
  assign valid_o   = (credits_q != `MCL_CREDIT_W'(`MCL_RX_DEPTH));
  assign head_o    = mem[rd_ptr_q];

endmodule

//--- hdl/mcl_rx_unpacker.sv
`include "mcl_bridge_macros.svh"

module mcl_rx_unpacker (
  input  logic                    clk_i
  ,input  logic                   rst_n_i
  ,input  mcl_bridge_pkg::flit_t  head_i
  ,input  logic                   valid_i
  ,input  logic                   pop_i
  ,output mcl_bridge_pkg::word_t  word_o
  ,output logic                   valid_o
  ,output logic                   deq_o
);

  localparam logic [1:0] LAST_IDX = 2'(`MCL_WORDS_PER_FLIT - 1);

  logic [1:0] idx_q; // next word of the head flit
  logic       take;

  assign take = pop_i && valid_i;

  // ----------------------------------------------------------------------
  // word index
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      idx_q <= 2'd0;
    end else if (take) begin
      idx_q <= idx_q + 2'd1; // wraps onto the next flit
    end
  end

  // low word first
  assign word_o  = head_i[idx_q*`MCL_WORD_W +: `MCL_WORD_W];
  assign valid_o = valid_i;

  // last word taken, release the flit
  assign deq_o = take && (idx_q == LAST_IDX);

endmodule

//--- hdl/mcl_host_bridge.sv
`include "mcl_bridge_macros.svh"

module mcl_host_bridge (
  input  logic                       clk_i
  ,input  logic                      rst_n_i
  // host register port
  ,input  logic                      wr_stb_i
  ,input  logic                      rd_stb_i
  ,input  mcl_bridge_pkg::reg_addr_e addr_i
  ,input  mcl_bridge_pkg::word_t     wdata_i
  ,output mcl_bridge_pkg::word_t     rdata_o
  ,output logic                      rvalid_o
  // fabric transmit
  ,output logic                      mcl_v_o
  ,output mcl_bridge_pkg::flit_t     mcl_data_o
  ,input  logic                      mcl_r_i
  // fabric receive
  ,input  logic                      mcl_v_i
  ,input  mcl_bridge_pkg::flit_t     mcl_data_i
  ,output logic                      mcl_r_o
);

  import mcl_bridge_pkg::*;

  logic                     tx_push;
  word_t                    tx_word;
  logic                     tx_busy;
  logic                     rx_pop;
  word_t                    rx_word;
  logic                     rx_valid;
  logic [`MCL_CREDIT_W-1:0] credits;
  flit_t                    fifo_head;
  logic                     fifo_valid;
  logic                     fifo_deq;

  // ----------------------------------------------------------------------
  // host side
  // ----------------------------------------------------------------------
  mcl_host_regs i_mcl_host_regs (
    .clk_i      (clk_i   ),
    .rst_n_i    (rst_n_i ),
    .wr_stb_i   (wr_stb_i),
    .rd_stb_i   (rd_stb_i),
    .addr_i     (addr_i  ),
    .wdata_i    (wdata_i ),
    .tx_busy_i  (tx_busy ),
    .rx_word_i  (rx_word ),
    .rx_valid_i (rx_valid),
    .credits_i  (credits ),
    .tx_push_o  (tx_push ),
    .tx_word_o  (tx_word ),
    .rx_pop_o   (rx_pop  ),
    .rdata_o    (rdata_o ),
    .rvalid_o   (rvalid_o)
  );

  // ----------------------------------------------------------------------
  // transmit, 32 -> 128
  // ----------------------------------------------------------------------
  mcl_tx_packer i_mcl_tx_packer (
    .clk_i      (clk_i     ),
    .rst_n_i    (rst_n_i   ),
    .push_i     (tx_push   ),
    .word_i     (tx_word   ),
    .mcl_r_i    (mcl_r_i   ),
    .busy_o     (tx_busy   ),
    .mcl_v_o    (mcl_v_o   ),
    .mcl_data_o (mcl_data_o)
  );

  // ----------------------------------------------------------------------
  // receive, 128 -> 32
  // ----------------------------------------------------------------------
  mcl_rx_fifo i_mcl_rx_fifo (
    .clk_i      (clk_i     ),
    .rst_n_i    (rst_n_i   ),
    .mcl_v_i    (mcl_v_i   ),
    .mcl_data_i (mcl_data_i),
    .deq_i      (fifo_deq  ),
    .mcl_r_o    (mcl_r_o   ),
    .head_o     (fifo_head ),
    .valid_o    (fifo_valid),
    .credits_o  (credits   )  // vacancy report
  );

  mcl_rx_unpacker i_mcl_rx_unpacker (
    .clk_i   (clk_i     ),
    .rst_n_i (rst_n_i   ),
    .head_i  (fifo_head ),
    .valid_i (fifo_valid),
    .pop_i   (rx_pop    ),
    .word_o  (rx_word   ),
    .valid_o (rx_valid  ),
    .deq_o   (fifo_deq  )
  );

endmodule

//--- verification/mcl_host_bridge_checker.sv
`include "mcl_bridge_macros.svh"

module mcl_host_bridge_checker (
  input  logic                       clk_i
  ,input  logic                      rst_n_i
  ,input  logic                      rd_stb_i
  ,input  logic                      rvalid_i
  ,input  logic                      tx_v_i
  ,input  logic                      tx_r_i
  ,input  mcl_bridge_pkg::flit_t     tx_data_i
  ,input  logic [`MCL_CREDIT_W-1:0]  credits_i
);
  timeunit 1ns;
  timeprecision 1ps;

  logic fail_seen = 1'b0; // raised by any failing assertion

  // ----------------------------------------------------------------------
  // fabric transmit
  // ----------------------------------------------------------------------
  tx_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    tx_v_i && !tx_r_i |=> tx_v_i && $stable(tx_data_i))
    else begin
      fail_seen = 1'b1;
      $error("transmit flit withdrawn or changed before acceptance");
    end

  // ----------------------------------------------------------------------
  // host port and credits
  // ----------------------------------------------------------------------
  rvalid_follows_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rd_stb_i |=> rvalid_i)
    else begin
      fail_seen = 1'b1;
      $error("read strobe not answered one cycle later");
    end

  rvalid_source_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_i |-> $past(rd_stb_i))
    else begin
      fail_seen = 1'b1;
      $error("read valid without a read strobe one cycle before");
    end

  credits_max_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    credits_i <= `MCL_RX_DEPTH)
    else begin
      fail_seen = 1'b1;
      $error("credit count above receive fifo depth");
    end

endmodule

bind mcl_host_bridge mcl_host_bridge_checker i_mcl_host_bridge_checker (
  .clk_i     (clk_i     ),
  .rst_n_i   (rst_n_i   ),
  .rd_stb_i  (rd_stb_i  ),
  .rvalid_i  (rvalid_o  ),
  .tx_v_i    (mcl_v_o   ),
  .tx_r_i    (mcl_r_i   ),
  .tx_data_i (mcl_data_o),
  .credits_i (credits   )  // internal fifo vacancy
);

//--- verification/tb_mcl_host_bridge.sv
`include "mcl_bridge_macros.svh"

module tb_mcl_host_bridge;
  timeunit 1ns;
  timeprecision 1ps;

  import mcl_bridge_pkg::*;

  localparam int CLK_PERIOD  = 20;
  localparam int DRIVE_DLY   = 2;
  localparam int TEST_CYCLES = 4 + 5 + 10 + 20 + 25 + 60; // reset plus each test
  localparam int WATCHDOG_NS = 2 * TEST_CYCLES * CLK_PERIOD; // double as margin
  localparam int WAIT_LIMIT  = 20; // cycles per fabric handshake

  logic      clk_i;
  logic      rst_n_i;
  logic      wr_stb_i;
  logic      rd_stb_i;
  reg_addr_e addr_i;
  word_t     wdata_i;
  word_t     rdata_o;
  logic      rvalid_o;
  logic      mcl_v_o;
  flit_t     mcl_data_o;
  logic      mcl_r_i;
  logic      mcl_v_i;
  flit_t     mcl_data_i;
  logic      mcl_r_o;

  integer seed = 15306;
  string  test_name = "none";
  flit_t  tx_flits [$]; // flits taken by the fabric
  word_t  rx_words [$]; // words the host should read back

  mcl_host_bridge i_mcl_host_bridge (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // handshake seen mid-cycle and transferred at the next rising edge
  always @(negedge clk_i) begin
    if (rst_n_i && mcl_v_o && mcl_r_i) tx_flits.push_back(mcl_data_o);
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check(input string label, input logic [127:0] expected,
                       input logic [127:0] actual);
    if (actual !== expected) begin
      $display("ERR %s %s: expected %0h actual %0h", test_name, label, expected, actual);
      abort_run("value mismatch");
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #DRIVE_DLY;
  endtask

  task automatic reg_write(input reg_addr_e addr, input word_t data);
    wr_stb_i = 1'b1;
    addr_i   = addr;
    wdata_i  = data;
    next_cycle();
    wr_stb_i = 1'b0;
  endtask

  task automatic read_expect(input string label, input reg_addr_e addr, input word_t expected);
    rd_stb_i = 1'b1;
    addr_i   = addr;
    next_cycle();
    rd_stb_i = 1'b0;
    check({label, " rvalid"}, 1, rvalid_o);
    check(label, expected, rdata_o);
  endtask

  task automatic random_flit(output flit_t f);
    f = {$random(seed), $random(seed), $random(seed), $random(seed)};
  endtask

  task automatic expect_words(input flit_t f);
    for (int k = 0; k < `MCL_WORDS_PER_FLIT; k++) begin
      rx_words.push_back(f[k*`MCL_WORD_W +: `MCL_WORD_W]); // low word first
    end
  endtask

  task automatic wait_flit_taken();
    int   n;
    logic taken;
    n     = 0;
    taken = 1'b0;
    while (!taken) begin
      taken = mcl_r_o; // ready is stable after the drive delay
      next_cycle();
      n++;
      if (n > WAIT_LIMIT) abort_run("receive flit never accepted by the bridge");
    end
    mcl_v_i = 1'b0;
  endtask

  task automatic send_flit();
    flit_t f;
    random_flit(f);
    expect_words(f);
    mcl_v_i    = 1'b1;
    mcl_data_i = f;
    wait_flit_taken();
  endtask

  task automatic wait_tx_count(input int n);
    int k;
    k = 0;
    while (tx_flits.size() < n) begin
      next_cycle();
      k++;
      if (k > WAIT_LIMIT) abort_run("transmit flit never accepted by the fabric");
    end
  endtask

  task automatic read_rx_words(input int n);
    word_t expected;
    repeat (n) begin
      expected = rx_words.pop_front();
      read_expect("rx word", REG_RX_DATA, expected);
    end
  endtask

  // ----------------------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------------------
  task automatic test_reset();
    test_name = "reset";
    check("mcl_v_o", 0, mcl_v_o);
    check("mcl_r_o", 1, mcl_r_o);
    read_expect("credits", REG_CREDITS, `MCL_RX_DEPTH);
    read_expect("status", REG_STATUS, 32'h2); // rx_empty only
  endtask

  task automatic test_tx_pack();
    word_t w [4];
    test_name = "tx_pack";
    mcl_r_i   = 1'b1;
    for (int k = 0; k < 4; k++) begin
      w[k] = 32'h1000_0000 + k * 32'h0101;
      reg_write(REG_TX_DATA, w[k]);
    end
    check("mcl_v_o", 1, mcl_v_o);
    check("mcl_data_o", {w[3], w[2], w[1], w[0]}, mcl_data_o);
    wait_tx_count(1);
    repeat (2) next_cycle();
    check("accept count", 1, tx_flits.size()); // taken exactly once
    check("mcl_v_o idle", 0, mcl_v_o);
    check("accepted flit", {w[3], w[2], w[1], w[0]}, tx_flits[0]);
  endtask

  task automatic test_tx_backpressure();
    word_t a [4];
    word_t b [4];
    test_name = "tx_backpressure";
    mcl_r_i   = 1'b0;
    for (int k = 0; k < 4; k++) begin
      a[k] = 32'hA000_0000 | k;
      reg_write(REG_TX_DATA, a[k]);
    end
    read_expect("status busy", REG_STATUS, 32'h3);
    reg_write(REG_TX_DATA, 32'hDEAD_BEEF); // lands while busy
    check("held flit", {a[3], a[2], a[1], a[0]}, mcl_data_o);
    check("mcl_v_o held", 1, mcl_v_o);
    mcl_r_i = 1'b1;
    wait_tx_count(2);
    check("first flit", {a[3], a[2], a[1], a[0]}, tx_flits[1]);
    for (int k = 0; k < 4; k++) begin
      b[k] = 32'hB000_0000 | k;
      reg_write(REG_TX_DATA, b[k]);
    end
    wait_tx_count(3);
    check("second flit", {b[3], b[2], b[1], b[0]}, tx_flits[2]);
  endtask

  task automatic test_rx_unpack();
    test_name = "rx_unpack";
    repeat (3) send_flit();
    read_expect("credits", REG_CREDITS, `MCL_RX_DEPTH - 3);
    read_rx_words(3 * `MCL_WORDS_PER_FLIT);
    read_expect("status empty", REG_STATUS, 32'h2);
    read_expect("credits restored", REG_CREDITS, `MCL_RX_DEPTH);
  endtask

  task automatic test_rx_full();
    flit_t extra;
    test_name = "rx_full";
    repeat (`MCL_RX_DEPTH) send_flit();
    check("mcl_r_o full", 0, mcl_r_o);
    read_expect("credits", REG_CREDITS, 0);
    random_flit(extra);
    mcl_v_i    = 1'b1; // held against a full fifo
    mcl_data_i = extra;
    repeat (2) next_cycle();
    check("mcl_r_o held", 0, mcl_r_o);
    read_rx_words(`MCL_WORDS_PER_FLIT);
    check("mcl_r_o free", 1, mcl_r_o);
    expect_words(extra); // queued behind the older flits
    wait_flit_taken();
    check("mcl_r_o full again", 0, mcl_r_o);
    read_rx_words(`MCL_RX_DEPTH * `MCL_WORDS_PER_FLIT);
    read_expect("credits restored", REG_CREDITS, `MCL_RX_DEPTH);
  endtask

  // ----------------------------------------------------------------------
  // run
  // ----------------------------------------------------------------------
  initial begin
    #WATCHDOG_NS;
    abort_run("watchdog expired, the tests did not finish in time");
  end

  initial begin
    wait (i_mcl_host_bridge.i_mcl_host_bridge_checker.fail_seen);
    abort_run("an assertion in the bound checker failed");
  end

  initial begin
    rst_n_i    = 1'b0;
    wr_stb_i   = 1'b0;
    rd_stb_i   = 1'b0;
    addr_i     = REG_TX_DATA;
    wdata_i    = '0;
    mcl_r_i    = 1'b0;
    mcl_v_i    = 1'b0;
    mcl_data_i = '0;
    repeat (4) @(posedge clk_i);
    #DRIVE_DLY;
    rst_n_i = 1'b1;
    test_reset();
    test_tx_pack();
    test_tx_backpressure();
    test_rx_unpack();
    test_rx_full();
    $display("Regression passed");
    $finish;
  end

endmodule

//--- mcl_host_bridge.f
+incdir+hdl
hdl/mcl_bridge_pkg.sv
hdl/mcl_host_regs.sv
hdl/mcl_tx_packer.sv
hdl/mcl_rx_fifo.sv
hdl/mcl_rx_unpacker.sv
hdl/mcl_host_bridge.sv
verification/mcl_host_bridge_checker.sv
verification/tb_mcl_host_bridge.sv
